/* source/ciPkg.sv */
package ciPkg;

  localparam int ciWordWidth = 32;

  typedef logic [ciWordWidth-1:0] ciWord;

  // Custom instruction numbers as seen on ciN
  typedef enum logic [7:0] {
    ciSwapByte = 8'd1,
    ciDelay    = 8'd6,
    ciProfile  = 8'd12,
    ciRgbGray  = 8'd13,
    ciIllegal  = 8'd255
  } ciOpcode;

  // Counter select in operandA of a profile instruction
  typedef enum logic [1:0] {
    profCycles  = 2'd0,
    profStall   = 2'd1,
    profBusIdle = 2'd2
  } profileSelect;

  localparam int profileCount = 3;

endpackage

/* source/ciIssueIf.sv */
`timescale 1ns/100ps

interface ciIssueIf;
  import ciPkg::*;

  logic    valid;     // One cycle per issued instruction
  ciOpcode opcode;
  ciWord   operandA;
  ciWord   operandB;

  modport decode (
    output valid,
    output opcode,
    output operandA,
    output operandB
  );

  modport execute (
    input valid,
    input opcode,
    input operandA,
    input operandB
  );

endinterface

/* source/ciDecoder.sv */
`timescale 1ns/100ps

module ciDecoder (
  input  logic            s_systemClock,
  input  logic            s_pllLocked,
  input  logic            ciStart,
  input  logic [7:0]      ciN,
  input  ciPkg::ciWord    ciDataA,
  input  ciPkg::ciWord    ciDataB,
  ciIssueIf.decode        issue,
  output logic            illegal
);
  import ciPkg::*;

  ciOpcode s_decodedOpcode;
  logic    s_isIllegal;

  always_comb begin
    case (ciN)
      8'd1:    s_decodedOpcode = ciSwapByte;
      8'd6:    s_decodedOpcode = ciDelay;
      8'd12:   s_decodedOpcode = ciProfile;
      8'd13:   s_decodedOpcode = ciRgbGray;
      default: s_decodedOpcode = ciIllegal;
    endcase
  end

  assign s_isIllegal = (s_decodedOpcode == ciIllegal);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      issue.valid  <= 1'b0;
      issue.opcode <= ciIllegal;
      illegal      <= 1'b0;
    end else begin
      issue.valid  <= ciStart & ~s_isIllegal;
      illegal      <= ciStart & s_isIllegal; // Answered by the result mux
      if (ciStart) issue.opcode <= s_decodedOpcode;
    end
  end

  // Operands are only looked at together with valid
  always_ff @(posedge s_systemClock) begin
    if (ciStart) begin
      issue.operandA <= ciDataA;
      issue.operandB <= ciDataB;
    end
  end

endmodule

/* source/pixelAlu.sv */
`timescale 1ns/100ps

module pixelAlu (
  input  logic          s_systemClock,
  input  logic          s_pllLocked,
  ciIssueIf.execute     issue,
  output logic          done,
  output ciPkg::ciWord  result
);
  import ciPkg::*;

  logic        s_swapSelected, s_graySelected;
  ciWord       s_swapped;
  logic [4:0]  s_red5, s_blue5;
  logic [5:0]  s_green6;
  logic [7:0]  s_red8, s_green8, s_blue8;
  logic [15:0] s_weightedSum;
  ciWord       s_gray;

  assign s_swapSelected = issue.valid && (issue.opcode == ciSwapByte);
  assign s_graySelected = issue.valid && (issue.opcode == ciRgbGray);

  // Bit 0 of operandB picks halfword swap instead of full reversal
  assign s_swapped = issue.operandB[0] ?
                     {issue.operandA[23:16], issue.operandA[31:24],
                      issue.operandA[7:0], issue.operandA[15:8]} :
                     {issue.operandA[7:0], issue.operandA[15:8],
                      issue.operandA[23:16], issue.operandA[31:24]};

  assign s_red5   = issue.operandA[15:11];
  assign s_green6 = issue.operandA[10:5];
  assign s_blue5  = issue.operandA[4:0];

  // Widen to 8 bits by repeating the top bits
  assign s_red8   = {s_red5, s_red5[4:2]};
  assign s_green8 = {s_green6, s_green6[5:4]};
  assign s_blue8  = {s_blue5, s_blue5[4:2]};

  // Weights sum to 256, so the total fits in 16 bits
  assign s_weightedSum = 16'd77 * s_red8 + 16'd150 * s_green8 + 16'd29 * s_blue8;
  assign s_gray        = {{(ciWordWidth - 8){1'b0}}, s_weightedSum[15:8]};

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= s_swapSelected | s_graySelected;
      if (s_swapSelected) result <= s_swapped;
      else if (s_graySelected) result <= s_gray;
      else result <= '0; // Result is ORed with the other units
    end
  end

endmodule

/* source/delayUnit.sv */
`timescale 1ns/100ps

module delayUnit #(
  parameter int cyclesPerMicrosecond = 50
) (
  input  logic          s_systemClock,
  input  logic          s_pllLocked,
  ciIssueIf.execute     issue,
  output logic          done,
  output ciPkg::ciWord  result
);
  import ciPkg::*;

  localparam int prescaleWidth = (cyclesPerMicrosecond > 1) ? $clog2(cyclesPerMicrosecond) : 1;
  localparam logic [prescaleWidth-1:0] prescaleReload = prescaleWidth'(cyclesPerMicrosecond - 1);

  typedef enum logic [1:0] {idle, counting, finish} delayState;

  delayState                s_state;
  logic [prescaleWidth-1:0] s_prescaler;
  ciWord                    s_microseconds;
  logic                     s_tick, s_lastTick;

  assign s_tick     = (s_prescaler == '0);
  assign s_lastTick = (s_state == counting) && s_tick && (s_microseconds == 1);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_state        <= idle;
      s_prescaler    <= '0;
      s_microseconds <= '0;
    end else begin
      case (s_state)
        idle: if (issue.valid && issue.opcode == ciDelay) begin
          s_prescaler    <= prescaleReload;
          s_microseconds <= issue.operandA;
          s_state        <= (issue.operandA == '0) ? finish : counting;
        end
        counting: begin
          if (s_tick) begin
            s_prescaler    <= prescaleReload;
            s_microseconds <= s_microseconds - 1'b1;
          end else s_prescaler <= s_prescaler - 1'b1;
          if (s_lastTick) s_state <= idle;
        end
        default: s_state <= idle; // Zero delay only needs its one cycle
      endcase
    end
  end

  // Done on the last microsecond tick, or from finish for a zero delay
  assign done   = s_lastTick || (s_state == finish);
  assign result = '0;

endmodule

/* source/profileUnit.sv */
`timescale 1ns/100ps

module profileUnit (
  input  logic          s_systemClock,
  input  logic          s_pllLocked,
  ciIssueIf.execute     issue,
  input  logic          stall,
  input  logic          busIdle,
  output logic          done,
  output ciPkg::ciWord  result
);
  import ciPkg::*;

  ciWord                   s_counters [profileCount];
  logic [profileCount-1:0] s_enabled, s_activeEnable, s_clear, s_events;
  logic                    s_control;
  profileSelect            s_select;
  ciWord                   s_selectedCount;

  assign s_control = issue.valid && (issue.opcode == ciProfile);
  assign s_select  = profileSelect'(issue.operandA[1:0]);

  // operandB holds enable, disable and clear bits per counter
  assign s_activeEnable = s_control ?
      (s_enabled | issue.operandB[profileCount-1:0]) & ~issue.operandB[4 +: profileCount] :
      s_enabled;
  assign s_clear = s_control ? issue.operandB[8 +: profileCount] : '0;

  assign s_events[profCycles]  = 1'b1;
  assign s_events[profStall]   = stall;
  assign s_events[profBusIdle] = busIdle;

  assign s_selectedCount = (int'(s_select) < profileCount) ? s_counters[s_select] : '0;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_enabled <= '0;
      for (int i = 0; i < profileCount; i++) s_counters[i] <= '0;
    end else begin
      s_enabled <= s_activeEnable;
      for (int i = 0; i < profileCount; i++) begin
        if (s_clear[i]) s_counters[i] <= '0;
        else if (s_activeEnable[i] && s_events[i]) s_counters[i] <= s_counters[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      done   <= 1'b0;
      result <= '0;
    end else begin
      done   <= s_control;
      result <= s_control ? s_selectedCount : '0; // Value before this control applies
    end
  end

endmodule

/* source/ciResultMux.sv */
`timescale 1ns/100ps

module ciResultMux (
  input  logic          s_systemClock,
  input  logic          s_pllLocked,
  input  logic          aluDone,
  input  ciPkg::ciWord  aluResult,
  input  logic          delayDone,
  input  ciPkg::ciWord  delayResult,
  input  logic          profileDone,
  input  ciPkg::ciWord  profileResult,
  input  logic          illegal,
  output logic          ciDone,
  output ciPkg::ciWord  ciResult
);
  import ciPkg::*;

  logic  s_anyDone;
  logic  s_illegalReply;  // Illegal strobe lined up with the unit replies
  ciWord s_merged;

  assign s_anyDone = aluDone | delayDone | profileDone | s_illegalReply;

  // Idle units hold zero, so a plain OR picks the active reply
  assign s_merged = aluResult | delayResult | profileResult | {ciWordWidth{s_illegalReply}};

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_illegalReply <= 1'b0;
      ciDone         <= 1'b0;
      ciResult       <= '0;
    end else begin
      s_illegalReply <= illegal;
      ciDone         <= s_anyDone;
      ciResult       <= s_merged;
    end
  end

endmodule

/* source/ciCoprocessor.sv */
`timescale 1ns/100ps

module ciCoprocessor #(
  parameter int cyclesPerMicrosecond = 50
) (
  input  logic          s_systemClock,
  input  logic          s_pllLocked,
  input  logic          ciStart,
  input  logic [7:0]    ciN,
  input  ciPkg::ciWord  ciDataA,
  input  ciPkg::ciWord  ciDataB,
  input  logic          stall,
  input  logic          busIdle,
  output logic          ciDone,
  output ciPkg::ciWord  ciResult
);

  logic         s_illegal;
  logic         s_aluDone, s_delayDone, s_profileDone;
  ciPkg::ciWord s_aluResult, s_delayResult, s_profileResult;

  ciIssueIf issueBus ();

  ciDecoder decoder (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .issue         (issueBus.decode),
    .illegal       (s_illegal)
  );

  pixelAlu alu (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .issue         (issueBus.execute),
    .done          (s_aluDone),
    .result        (s_aluResult)
  );

  delayUnit #(.cyclesPerMicrosecond(cyclesPerMicrosecond)) delayMicro (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .issue         (issueBus.execute),
    .done          (s_delayDone),
    .result        (s_delayResult)
  );

  profileUnit profiler (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .issue         (issueBus.execute),
    .stall         (stall),
    .busIdle       (busIdle),
    .done          (s_profileDone),
    .result        (s_profileResult)
  );

  ciResultMux resultMux (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .aluDone       (s_aluDone),
    .aluResult     (s_aluResult),
    .delayDone     (s_delayDone),
    .delayResult   (s_delayResult),
    .profileDone   (s_profileDone),
    .profileResult (s_profileResult),
    .illegal       (s_illegal),
    .ciDone        (ciDone),
    .ciResult      (ciResult)
  );

endmodule

/* testbench/ciChecker.sv */
`timescale 1ns/100ps

module ciChecker (
  input  logic         s_systemClock,
  input  logic         s_pllLocked,
  input  logic         ciStart,
  input  logic         ciDone,
  input  ciPkg::ciWord ciResult,
  output int           mismatchErrors,
  output int           protocolErrors
);
  import ciPkg::*;

  string expName;
  ciWord expValue;
  int    expLatency;
  logic  armed;    // Expectation loaded, start not seen yet
  logic  waiting;  // Start seen, ciDone not seen yet
  int    cycle;
  int    startCycle;

  initial begin
    mismatchErrors = 0;
    protocolErrors = 0;
    armed = 1'b0;
    waiting = 1'b0;
    cycle = 0;
    startCycle = 0;
  end

  task automatic expectResult(input string name, input ciWord value, input int latency);
    expName = name;
    expValue = value;
    expLatency = latency;
    armed = 1'b1;
  endtask

  always @(posedge s_systemClock) begin
    cycle = cycle + 1;
    if (!s_pllLocked) begin
      if (ciDone !== 1'b0 || ciResult !== '0) begin
        $display("Error: ciDone or ciResult active during reset in cycle %0d", cycle);
        protocolErrors++;
      end
    end else begin
      if (ciDone === 1'b1) begin
        if (!waiting) begin
          $display("Error: unexpected ciDone in cycle %0d", cycle);
          protocolErrors++;
        end else begin
          if (ciResult !== expValue) begin
            $display("Mismatch in %s: expected %h, actual %h", expName, expValue, ciResult);
            mismatchErrors++;
          end
          if (cycle - startCycle != expLatency) begin
            $display("Error: %s finished after %0d cycles instead of %0d",
                     expName, cycle - startCycle, expLatency);
            protocolErrors++;
          end
          waiting = 1'b0;
        end
      end else if (waiting && (cycle - startCycle >= expLatency)) begin
        $display("Error: no ciDone for %s within %0d cycles", expName, expLatency);
        protocolErrors++;
        waiting = 1'b0;
      end
      if (ciStart === 1'b1) begin
        if (waiting) begin
          $display("Error: ciStart while %s is still running", expName);
          protocolErrors++;
        end
        if (!armed) begin
          $display("Error: ciStart in cycle %0d without an expected result", cycle);
          protocolErrors++;
        end else begin
          waiting = 1'b1;
          startCycle = cycle;
          armed = 1'b0;
        end
      end
    end
  end

endmodule

/* testbench/ciCoprocessor_sva.sv */
`timescale 1ns/100ps

module ciCoprocessor_sva (
  input logic         s_systemClock,
  input logic         s_pllLocked,
  input logic         ciStart,
  input logic         ciDone,
  input ciPkg::ciWord ciResult
);

  int   assertFailures = 0;
  logic s_outstanding;  // An instruction was started and has not finished

  always @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) s_outstanding <= 1'b0;
    else if (ciStart) s_outstanding <= 1'b1;
    else if (ciDone) s_outstanding <= 1'b0;
  end

  startAfterDone: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
      ciStart |-> !s_outstanding)
    else begin
      assertFailures++;
      $error("ciStart came before ciDone of the previous instruction");
    end

  resultOnlyWithDone: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
      !ciDone |-> (ciResult == '0))
    else begin
      assertFailures++;
      $error("ciResult is not zero while ciDone is low");
    end

  quietInReset: assert property (@(posedge s_systemClock) !s_pllLocked |-> !ciDone)
    else begin
      assertFailures++;
      $error("ciDone is high during reset");
    end

endmodule

bind ciCoprocessor ciCoprocessor_sva protocolChecks (.*);

/* testbench/ciCoprocessorTb.sv */
`timescale 1ns/100ps

module ciCoprocessorTb;
  import ciPkg::*;

  localparam int cyclesPerMicrosecond = 5;
  localparam int resetCycles = 10;
  localparam int swapCount = 40;
  localparam int grayRandomCount = 40;
  localparam int profileGap = 20;  // K, cycles between enable and disable
  localparam int delaySum = 3 + (2 + cyclesPerMicrosecond) + (2 + 3 * cyclesPerMicrosecond);
  localparam int expectedCycles = resetCycles + 2 * swapCount * 3 + (5 + grayRandomCount) * 3
                                  + delaySum + 9 * 3 + profileGap + 3 * 3;
  localparam int timeoutLimit = 2 * expectedCycles + 200;

  logic       s_systemClock, s_pllLocked;
  logic       ciStart, stall, busIdle, ciDone;
  logic [7:0] ciN;
  ciWord      ciDataA, ciDataB, ciResult;
  int         seed;
  int         cycleCount = 0;
  int         lastStartCycle = 0;
  int         timeoutErrors = 0;
  int         mismatchErrors, protocolErrors;
  ciWord      modelCycles, modelStall, modelBusIdle;  // Expected profile counters

  ciCoprocessor #(.cyclesPerMicrosecond(cyclesPerMicrosecond)) DUT (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .stall         (stall),
    .busIdle       (busIdle),
    .ciDone        (ciDone),
    .ciResult      (ciResult)
  );

  ciChecker resultChecker (
    .s_systemClock  (s_systemClock),
    .s_pllLocked    (s_pllLocked),
    .ciStart        (ciStart),
    .ciDone         (ciDone),
    .ciResult       (ciResult),
    .mismatchErrors (mismatchErrors),
    .protocolErrors (protocolErrors)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #10 s_systemClock = ~s_systemClock;
  end

  function automatic ciWord refResult(input logic [7:0] n, input ciWord a, input ciWord b);
    ciWord      r;
    logic [7:0] red8, green8, blue8;
    int         sum;
    r = '0;
    case (n)
      ciSwapByte: begin
        for (int i = 0; i < 4; i++)
          r[8*i +: 8] = b[0] ? a[8*(i ^ 1) +: 8] : a[8*(3 - i) +: 8];
      end
      ciRgbGray: begin
        red8 = {a[15:11], a[15:13]};
        green8 = {a[10:5], a[10:9]};
        blue8 = {a[4:0], a[4:2]};
        sum = 77 * red8 + 150 * green8 + 29 * blue8;
        r = ciWord'(sum >> 8);
      end
      ciDelay: r = '0;
      ciProfile: begin
        case (a[1:0])
          2'd0: r = modelCycles;
          2'd1: r = modelStall;
          2'd2: r = modelBusIdle;
          default: r = '0;
        endcase
      end
      default: r = '1;  // Unknown numbers answer all ones
    endcase
    return r;
  endfunction

  function automatic int refLatency(input logic [7:0] n, input ciWord a);
    if (n == ciDelay) return 2 + ((a == '0) ? 1 : int'(a) * cyclesPerMicrosecond);
    return 3;
  endfunction

  task automatic runInstruction(input string name, input logic [7:0] n, input ciWord a,
                                input ciWord b);
    ciWord expected;
    int    latency;
    expected = refResult(n, a, b);
    latency = refLatency(n, a);
    @(posedge s_systemClock);
    #2;
    resultChecker.expectResult(name, expected, latency);
    ciStart = 1'b1;
    ciN = n;
    ciDataA = a;
    ciDataB = b;
    lastStartCycle = cycleCount;
    @(posedge s_systemClock);
    #2 ciStart = 1'b0;
    do begin
      @(posedge s_systemClock);
      #1;
    end while (ciDone !== 1'b1);
  endtask

  task automatic waitUntilCycle(input int target);
    while (cycleCount < target) begin
      @(posedge s_systemClock);
      #1;
    end
  endtask

  task automatic applyReset;
    #1 s_pllLocked = 1'b0;  // Clean falling edge into reset
    repeat (3) @(posedge s_systemClock);
    #2;
    ciStart = 1'b1;  // Must be ignored while unlocked
    ciN = ciSwapByte;
    ciDataA = 32'h12345678;
    repeat (2) @(posedge s_systemClock);
    #2 ciStart = 1'b0;
    repeat (resetCycles - 5) @(posedge s_systemClock);
    #2 s_pllLocked = 1'b1;
  endtask

  task automatic testSwap;
    ciWord a, b;
    for (int i = 0; i < swapCount; i++) begin
      a = $random(seed);
      b = $random(seed);
      runInstruction("swap reverse", ciSwapByte, a, {b[31:1], 1'b0});
      runInstruction("swap halfwords", ciSwapByte, a, {b[31:1], 1'b1});
    end
  endtask

  task automatic testGray;
    ciWord a, b;
    runInstruction("gray black", ciRgbGray, 32'h0000, '0);
    runInstruction("gray white", ciRgbGray, 32'hFFFF, '0);
    runInstruction("gray red", ciRgbGray, 32'hF800, '0);
    runInstruction("gray green", ciRgbGray, 32'h07E0, '0);
    runInstruction("gray blue", ciRgbGray, 32'h001F, '0);
    for (int i = 0; i < grayRandomCount; i++) begin
      a = $random(seed);  // Upper half must be ignored
      b = $random(seed);
      runInstruction("gray random", ciRgbGray, a, b);
    end
  endtask

  task automatic testDelay;
    runInstruction("delay 0us", ciDelay, 32'd0, '0);
    runInstruction("delay 1us", ciDelay, 32'd1, '0);
    runInstruction("delay 3us", ciDelay, 32'd3, '0);
  endtask

  task automatic testProfile;
    int enableCycle;
    #2;
    stall = 1'b1;
    busIdle = 1'b0;
    runInstruction("profile enable", ciProfile, 32'd0, 32'h007);
    enableCycle = lastStartCycle;
    waitUntilCycle(enableCycle + profileGap - 1);
    // Every cycle from enable valid up to disable valid counts, K in total
    modelCycles = profileGap;
    modelStall = profileGap;
    modelBusIdle = 0;
    runInstruction("profile disable", ciProfile, 32'd0, 32'h070);
    stall = 1'b0;
    runInstruction("profile read cycles", ciProfile, 32'd0, '0);
    runInstruction("profile read stall", ciProfile, 32'd1, '0);
    runInstruction("profile read busIdle", ciProfile, 32'd2, '0);
    runInstruction("profile select 3", ciProfile, 32'd3, '0);
    runInstruction("profile clear", ciProfile, 32'd0, 32'h700);  // Reply is the old value
    modelCycles = 0;
    modelStall = 0;
    runInstruction("profile read after clear", ciProfile, 32'd0, '0);
    runInstruction("profile stall after clear", ciProfile, 32'd1, '0);
  endtask

  task automatic testIllegal;
    ciWord a, b;
    a = $random(seed);
    b = $random(seed);
    runInstruction("illegal 0", 8'd0, a, b);
    runInstruction("illegal 4", 8'd4, b, a);
    runInstruction("illegal 200", 8'd200, a, b);
  endtask

  task automatic finishRun;
    int assertErrors;
    int total;
    assertErrors = DUT.protocolChecks.assertFailures;
    total = mismatchErrors + protocolErrors + assertErrors + timeoutErrors;
    $display("Errors: %0d mismatch, %0d protocol, %0d assertion, %0d timeout",
             mismatchErrors, protocolErrors, assertErrors, timeoutErrors);
    if (total == 0) $display("Verification passed");
    else $display("Verification failed");
    $finish;
  endtask

  always @(posedge s_systemClock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == timeoutLimit) begin
      $display("Error: timeout after %0d cycles, the DUT stopped answering", cycleCount);
      timeoutErrors = 1;
      finishRun();
    end
  end

  initial begin
    seed = 32'h0fc8329c;
    s_pllLocked = 1'b1;
    ciStart = 1'b0;
    ciN = '0;
    ciDataA = '0;
    ciDataB = '0;
    stall = 1'b0;
    busIdle = 1'b0;
    modelCycles = '0;
    modelStall = '0;
    modelBusIdle = '0;
    applyReset();
    testSwap();
    testGray();
    testDelay();
    testProfile();
    testIllegal();
    repeat (5) @(posedge s_systemClock);
    finishRun();
  end

endmodule

/* all.f */
source/ciPkg.sv
source/ciIssueIf.sv
source/ciDecoder.sv
source/pixelAlu.sv
source/delayUnit.sv
source/profileUnit.sv
source/ciResultMux.sv
source/ciCoprocessor.sv
testbench/ciChecker.sv
testbench/ciCoprocessor_sva.sv
testbench/ciCoprocessorTb.sv

/* Bender.yml */
package:
  name: ciCoprocessor

sources:
  - files:
      - source/ciPkg.sv
      - source/ciIssueIf.sv
      - source/ciDecoder.sv
      - source/pixelAlu.sv
      - source/delayUnit.sv
      - source/profileUnit.sv
      - source/ciResultMux.sv
      - source/ciCoprocessor.sv
  - target: test
    files:
      - testbench/ciChecker.sv
      - testbench/ciCoprocessor_sva.sv
      - testbench/ciCoprocessorTb.sv
